//--- project.f
+incdir+design
design/hr_pkg.sv
design/hr_entry.sv
design/rr_arbiter.sv
design/tl_a_arbiter.sv
design/resp_collector.sv
design/axi2tl_bridge.sv
bench/tl_responder.sv
bench/tb_axi2tl.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI to TileLink bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_axi2tl \
	-f project.f \
	-o sim_axi2tl

out=$(./obj_dir/sim_axi2tl)
echo "$out"
echo "$out" | grep -qx "Done: no errors"

//--- bench/tb_axi2tl.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module tb_axi2tl;

	localparam int NUM_ROWS = 12;

	typedef struct packed {
		logic [`HR_ID_W-1:0] id;
		logic [`HR_ADDR_W-1:0] addr;
		logic [`HR_LEN_W-1:0] len;
		logic [`HR_STRB_W-1:0] strb;
		logic [`HR_DATA_W-1:0] base;
		logic denied;
		// 0 drains responses first, 1 overlaps, 2 overlaps under B stall
		logic [1:0] mode;
	} row_t;

	logic clk;
	logic resetn;
	logic ax_valid;
	hr_pkg::ax_cmd_t ax;
	logic ax_ready;
	logic w_valid;
	hr_pkg::w_beat_t w;
	logic w_ready;
	logic a_valid;
	hr_pkg::tl_a_t a;
	logic a_ready;
	logic d_valid;
	hr_pkg::tl_d_t d;
	logic d_ready;
	logic b_valid;
	hr_pkg::b_resp_t b;
	logic b_ready;

	row_t tbl [NUM_ROWS];
	int cur_row [`HR_ENTRIES];
	int beat_idx [`HR_ENTRIES];
	logic [`HR_ENTRIES-1:0] burst_open;
	logic [`HR_ENTRIES-1:0] acked;
	logic [`HR_ENTRIES-1:0] deny_map;
	int pend_rows [$];
	int b_hold_cycles;
	logic locked;
	logic [`HR_ID_W-1:0] lock_src;
	int checks;
	int errors;

	axi2tl_bridge i_dut (
		.clk(clk),
		.resetn(resetn),
		.ax_valid(ax_valid),
		.ax(ax),
		.ax_ready(ax_ready),
		.w_valid(w_valid),
		.w(w),
		.w_ready(w_ready),
		.a_valid(a_valid),
		.a(a),
		.a_ready(a_ready),
		.d_valid(d_valid),
		.d(d),
		.d_ready(d_ready),
		.b_valid(b_valid),
		.b(b),
		.b_ready(b_ready)
	);

	tl_responder i_slave (
		.clk(clk),
		.resetn(resetn),
		.a_valid(a_valid),
		.a(a),
		.a_ready(a_ready),
		.d_valid(d_valid),
		.d(d),
		.d_ready(d_ready),
		.deny(deny_map)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	function automatic void load_table();
		tbl[0] = '{2'd0, 32'h0000_1000, 2'd0, 4'hf, 32'h0000_0100, 1'b0, 2'd0};
		tbl[1] = '{2'd1, 32'h0000_2000, 2'd1, 4'hf, 32'h0000_0200, 1'b0, 2'd0};
		tbl[2] = '{2'd2, 32'h0000_3000, 2'd3, 4'h3, 32'h0000_0300, 1'b1, 2'd0};
		tbl[3] = '{2'd3, 32'h0000_4000, 2'd3, 4'hf, 32'h0000_0400, 1'b0, 2'd0};
		tbl[4] = '{2'd0, 32'h0000_5000, 2'd1, 4'hc, 32'h0000_0500, 1'b1, 2'd1};
		tbl[5] = '{2'd1, 32'h0000_6000, 2'd3, 4'hf, 32'h0000_0600, 1'b0, 2'd1};
		tbl[6] = '{2'd2, 32'h0000_7000, 2'd0, 4'h1, 32'h0000_0700, 1'b0, 2'd2};
		tbl[7] = '{2'd3, 32'h0000_8000, 2'd1, 4'hf, 32'h0000_0800, 1'b1, 2'd2};
		tbl[8] = '{2'd0, 32'h0000_9000, 2'd0, 4'hf, 32'h0000_0900, 1'b0, 2'd2};
		tbl[9] = '{2'd1, 32'h0000_a000, 2'd1, 4'he, 32'h0000_0a00, 1'b0, 2'd2};
		tbl[10] = '{2'd2, 32'h0000_b000, 2'd3, 4'hf, 32'h0000_0b00, 1'b1, 2'd2};
		tbl[11] = '{2'd3, 32'h0000_c000, 2'd0, 4'h7, 32'h0000_0c00, 1'b0, 2'd0};
	endfunction

	// Called at the edge where the command was accepted
	task automatic note_accept(input int r);
		int id;
		int open;
		id = tbl[r].id;
		open = 0;
		foreach (pend_rows[k])
			if (tbl[pend_rows[k]].id == id)
				open++;
		if (burst_open[id])
			note_error($sformatf("command on id %0d accepted during its burst", id));
		// An entry stays busy at least until its AccessAck has arrived
		if (open != 0 && !acked[id])
			note_error($sformatf("command on id %0d accepted before its ack", id));
		cur_row[id] = r;
		beat_idx[id] = 0;
		burst_open[id] = 1'b1;
		acked[id] <= 1'b0;
		deny_map[id] = tbl[r].denied;
		pend_rows.push_back(r);
	endtask

	task automatic send_row(input int r);
		row_t row;
		logic accepted;
		row = tbl[r];
		@(negedge clk);
		ax_valid = 1'b1;
		ax.id = row.id;
		ax.addr = row.addr;
		ax.len = row.len;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = ax_ready;
		end
		note_accept(r);
		for (int beat = 0; beat <= int'(row.len); beat++) begin
			@(negedge clk);
			ax_valid = 1'b0;
			w_valid = 1'b1;
			w.id = row.id;
			w.data = row.base + 32'(beat);
			w.strb = row.strb;
			w.last = (beat == int'(row.len));
			accepted = 1'b0;
			while (!accepted) begin
				@(posedge clk);
				accepted = w_ready;
			end
		end
		@(negedge clk);
		w_valid = 1'b0;
		@(posedge clk);
	endtask

	task automatic wait_drain();
		while (pend_rows.size() != 0)
			@(posedge clk);
	endtask

	task automatic check_a_beat();
		int src;
		row_t row;
		src = a.source;
		if (locked && src != int'(lock_src))
			note_error("A beats of two bursts interleaved");
		if (!burst_open[src]) begin
			note_error($sformatf("A beat from source %0d with no open burst", src));
		end else begin
			row = tbl[cur_row[src]];
			check_value("a.address", a.address, row.addr);
			check_value("a.size", a.size, row.len == 0 ? 2 : (row.len == 1 ? 3 : 4));
			check_value("a.data", a.data, row.base + 32'(beat_idx[src]));
			check_value("a.mask", a.mask, row.strb);
			check_value("a.opcode", a.opcode,
				(row.strb == 4'hf) ? hr_pkg::PUT_FULL : hr_pkg::PUT_PARTIAL);
			check_value("a.last", a.last, beat_idx[src] == int'(row.len));
			beat_idx[src]++;
			if (beat_idx[src] > int'(row.len))
				burst_open[src] = 1'b0;
		end
		locked = !a.last;
		lock_src = a.source;
	endtask

	// Responses match by id, oldest first
	task automatic take_b();
		int hit;
		hit = -1;
		foreach (pend_rows[k])
			if (hit < 0 && tbl[pend_rows[k]].id == b.id)
				hit = k;
		if (hit < 0) begin
			note_error($sformatf("B response for id %0d with no open write", b.id));
		end else begin
			check_value("b.resp", b.resp,
				tbl[pend_rows[hit]].denied ? hr_pkg::SLVERR : hr_pkg::OKAY);
			pend_rows.delete(hit);
		end
	endtask

	always @(posedge clk) begin
		if (resetn && a_valid && a_ready)
			check_a_beat();
		if (resetn && d_valid && d_ready)
			acked[d.source] <= 1'b1;
		if (resetn && b_valid && b_ready)
			take_b();
	end

	initial begin
		b_ready = 1'b0;
		forever begin
			@(negedge clk);
			if (b_hold_cycles > 0) begin
				b_ready = 1'b0;
				b_hold_cycles--;
			end else begin
				b_ready = 1'b1;
			end
		end
	end

	initial begin
		repeat (NUM_ROWS * 200) @(posedge clk);
		$display("Timeout: the transactions did not complete in time");
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic hold_started;
		resetn = 1'b0;
		ax_valid = 1'b0;
		ax = '0;
		w_valid = 1'b0;
		w = '0;
		deny_map = '0;
		burst_open = '0;
		acked = '0;
		locked = 1'b0;
		lock_src = '0;
		b_hold_cycles = 0;
		checks = 0;
		errors = 0;
		hold_started = 1'b0;
		load_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		@(posedge clk);
		check_value("a_valid", a_valid, 0);
		check_value("b_valid", b_valid, 0);
		check_value("w_ready", w_ready, 0);
		check_value("d_ready", d_ready, 0);
		check_value("ax_ready", ax_ready, 1);

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (tbl[r].mode == 2'd0)
				wait_drain();
			// Hold B off long enough to fill the response FIFO
			if (tbl[r].mode == 2'd2 && !hold_started) begin
				hold_started = 1'b1;
				b_hold_cycles = 60;
			end
			send_row(r);
		end
		wait_drain();
		repeat (20) @(posedge clk);
		if (burst_open != '0)
			note_error("a burst never completed on the A channel");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- bench/tl_responder.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module tl_responder (
	input  logic clk,
	input  logic resetn,
	input  logic a_valid,
	input  hr_pkg::tl_a_t a,
	output logic a_ready,
	output logic d_valid,
	output hr_pkg::tl_d_t d,
	input  logic d_ready,
	input  logic [`HR_ENTRIES-1:0] deny
);

	integer seed;
	logic d_sent;
	logic [`HR_ID_W-1:0] ack_q [$];

	initial begin
		seed = 27;
		a_ready = 1'b0;
		d_valid = 1'b0;
		d = '0;
		d_sent = 1'b0;
	end

	// Bursts end on a.last, one ack each
	always @(posedge clk) begin
		if (resetn && a_valid && a_ready && a.last)
			ack_q.push_back(a.source);
		if (resetn && d_valid && d_ready)
			d_sent = 1'b1;
	end

	always @(negedge clk) begin
		// Ready about three cycles in four
		a_ready = (($random(seed) & 3) != 0);
		if (d_sent || !d_valid) begin
			d_sent = 1'b0;
			if (ack_q.size() != 0) begin
				d_valid = 1'b1;
				d.opcode = hr_pkg::ACCESS_ACK;
				d.source = ack_q.pop_front();
				d.denied = deny[d.source];
			end else begin
				d_valid = 1'b0;
			end
		end
	end

endmodule

//--- design/axi2tl_bridge.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module axi2tl_bridge (
	input  logic clk,
	input  logic resetn,
	input  logic ax_valid,
	input  hr_pkg::ax_cmd_t ax,
	output logic ax_ready,
	input  logic w_valid,
	input  hr_pkg::w_beat_t w,
	output logic w_ready,
	output logic a_valid,
	output hr_pkg::tl_a_t a,
	input  logic a_ready,
	input  logic d_valid,
	input  hr_pkg::tl_d_t d,
	output logic d_ready,
	output logic b_valid,
	output hr_pkg::b_resp_t b,
	input  logic b_ready
);

	logic [`HR_ENTRIES-1:0] ent_cmd_valid;
	logic [`HR_ENTRIES-1:0] ent_cmd_ready;
	logic [`HR_ENTRIES-1:0] ent_w_valid;
	logic [`HR_ENTRIES-1:0] ent_w_ready;
	logic [`HR_ENTRIES-1:0] ent_a_req;
	logic [`HR_ENTRIES-1:0] ent_a_take;
	logic [`HR_ENTRIES-1:0] ent_d_valid;
	logic [`HR_ENTRIES-1:0] ent_d_ready;
	logic [`HR_ENTRIES-1:0] ent_b_req;
	logic [`HR_ENTRIES-1:0] ent_b_take;
	hr_pkg::tl_a_t ent_beats [`HR_ENTRIES];
	hr_pkg::axi_resp_e ent_resp [`HR_ENTRIES];

	// The AXI ID and the TL source both name the entry
	assign ax_ready = ent_cmd_ready[ax.id];
	assign w_ready = ent_w_ready[w.id];
	assign d_ready = ent_d_ready[d.source];

	for (genvar g = 0; g < `HR_ENTRIES; g++) begin : g_entry
		assign ent_cmd_valid[g] = ax_valid && (ax.id == `HR_ID_W'(g));
		assign ent_w_valid[g] = w_valid && (w.id == `HR_ID_W'(g));
		assign ent_d_valid[g] = d_valid && (d.source == `HR_ID_W'(g));

		hr_entry i_entry (
			.clk(clk),
			.resetn(resetn),
			.cmd_valid(ent_cmd_valid[g]),
			.cmd(ax),
			.cmd_ready(ent_cmd_ready[g]),
			.w_valid(ent_w_valid[g]),
			.w(w),
			.w_ready(ent_w_ready[g]),
			.a_req(ent_a_req[g]),
			.a_beat(ent_beats[g]),
			.a_take(ent_a_take[g]),
			.d_valid(ent_d_valid[g]),
			.d(d),
			.d_ready(ent_d_ready[g]),
			.b_req(ent_b_req[g]),
			.b_resp(ent_resp[g]),
			.b_take(ent_b_take[g]),
			.source(`HR_ID_W'(g))
		);
	end

	tl_a_arbiter i_a_arb (
		.clk(clk),
		.resetn(resetn),
		.req(ent_a_req),
		.beats(ent_beats),
		.take(ent_a_take),
		.a_valid(a_valid),
		.a(a),
		.a_ready(a_ready)
	);

	resp_collector i_resp (
		.clk(clk),
		.resetn(resetn),
		.req(ent_b_req),
		.resp(ent_resp),
		.take(ent_b_take),
		.b_valid(b_valid),
		.b(b),
		.b_ready(b_ready)
	);

endmodule

//--- design/resp_collector.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module resp_collector (
	input  logic clk,
	input  logic resetn,
	input  logic [`HR_ENTRIES-1:0] req,
	input  hr_pkg::axi_resp_e resp [`HR_ENTRIES],
	output logic [`HR_ENTRIES-1:0] take,
	output logic b_valid,
	output hr_pkg::b_resp_t b,
	input  logic b_ready
);

	localparam int PTR_W = $clog2(`HR_RESP_DEPTH);

	hr_pkg::b_resp_t fifo_mem [`HR_RESP_DEPTH];
	logic [PTR_W:0] wr_ptr_q;
	logic [PTR_W:0] rd_ptr_q;
	logic full;
	logic empty;
	logic push;
	logic pop;
	logic [`HR_ENTRIES-1:0] grant;
	hr_pkg::b_resp_t push_data;

	// Extra pointer bit tells full from empty
	assign empty = (wr_ptr_q == rd_ptr_q);
	assign full = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
		(wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

	rr_arbiter i_arb (
		.clk(clk),
		.resetn(resetn),
		.req(req & {`HR_ENTRIES{!full}}),
		.hold(1'b0),
		.grant(grant)
	);

	assign take = grant;
	assign push = |grant;
	assign pop = b_valid && b_ready;

	always_comb begin
		push_data.id = '0;
		push_data.resp = hr_pkg::OKAY;
		for (int i = 0; i < `HR_ENTRIES; i++) begin
			if (grant[i]) begin
				push_data.id = `HR_ID_W'(i);
				push_data.resp = resp[i];
			end
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			fifo_mem[wr_ptr_q[PTR_W-1:0]] <= push_data;
	end

	assign b_valid = !empty;
	assign b = fifo_mem[rd_ptr_q[PTR_W-1:0]];

endmodule

//--- design/tl_a_arbiter.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module tl_a_arbiter (
	input  logic clk,
	input  logic resetn,
	input  logic [`HR_ENTRIES-1:0] req,
	input  hr_pkg::tl_a_t beats [`HR_ENTRIES],
	output logic [`HR_ENTRIES-1:0] take,
	output logic a_valid,
	output hr_pkg::tl_a_t a,
	input  logic a_ready
);

	logic lock_q;
	logic stall_q;
	logic [`HR_ENTRIES-1:0] grant;

	// Stay on the owner inside a burst and while a beat is stalled
	rr_arbiter i_arb (
		.clk(clk),
		.resetn(resetn),
		.req(req),
		.hold(lock_q || stall_q),
		.grant(grant)
	);

	always_comb begin
		a = '0;
		for (int i = 0; i < `HR_ENTRIES; i++) begin
			if (grant[i])
				a = beats[i];
		end
	end

	assign a_valid = |grant;
	assign take = grant & {`HR_ENTRIES{a_ready}};

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			lock_q <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			if (a_valid && a_ready)
				lock_q <= !a.last;
			stall_q <= a_valid && !a_ready;
		end
	end

endmodule

//--- design/rr_arbiter.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module rr_arbiter (
	input  logic clk,
	input  logic resetn,
	input  logic [`HR_ENTRIES-1:0] req,
	input  logic hold,
	output logic [`HR_ENTRIES-1:0] grant
);

	logic [`HR_ID_W-1:0] ptr_q;
	logic [`HR_ID_W-1:0] idx;
	logic [`HR_ID_W-1:0] win_idx;
	logic win;

	// Search starts just past the last granted entry
	always_comb begin
		win = 1'b0;
		win_idx = ptr_q;
		for (int i = 1; i <= `HR_ENTRIES; i++) begin
			idx = ptr_q + `HR_ID_W'(i);
			if (!win && req[idx]) begin
				win = 1'b1;
				win_idx = idx;
			end
		end
	end

	always_comb begin
		if (hold)
			grant = req & (`HR_ENTRIES'(1) << ptr_q);
		else if (win)
			grant = `HR_ENTRIES'(1) << win_idx;
		else
			grant = '0;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			ptr_q <= `HR_ID_W'(`HR_ENTRIES - 1);
		else if (!hold && win)
			ptr_q <= win_idx;
	end

endmodule

//--- design/hr_entry.sv
`timescale 1ns/100ps
`include "hr_params.svh"

module hr_entry (
	input  logic clk,
	input  logic resetn,
	input  logic cmd_valid,
	input  hr_pkg::ax_cmd_t cmd,
	output logic cmd_ready,
	input  logic w_valid,
	input  hr_pkg::w_beat_t w,
	output logic w_ready,
	output logic a_req,
	output hr_pkg::tl_a_t a_beat,
	input  logic a_take,
	input  logic d_valid,
	input  hr_pkg::tl_d_t d,
	output logic d_ready,
	output logic b_req,
	output hr_pkg::axi_resp_e b_resp,
	input  logic b_take,
	input  logic [`HR_ID_W-1:0] source
);

	hr_pkg::hr_state_e state_q;
	logic [`HR_LEN_W-1:0] cnt_q;
	logic [`HR_ADDR_W-1:0] addr_q;
	logic [`HR_LEN_W-1:0] len_q;
	logic beat_valid_q;
	logic [`HR_DATA_W-1:0] beat_data_q;
	logic [`HR_STRB_W-1:0] beat_strb_q;
	logic beat_last_q;
	hr_pkg::axi_resp_e resp_q;
	logic cmd_fire;
	logic w_fire;
	logic d_fire;

	assign cmd_ready = (state_q == hr_pkg::IDLE);
	assign d_ready = (state_q == hr_pkg::WAIT_ACK);
	assign b_req = (state_q == hr_pkg::RESP);
	assign b_resp = resp_q;
	assign a_req = beat_valid_q;

	// Refill while the held beat leaves, never past the final beat
	assign w_ready = (state_q == hr_pkg::DATA) &&
		(!beat_valid_q || (a_take && !beat_last_q));

	assign cmd_fire = cmd_valid && cmd_ready;
	assign w_fire = w_valid && w_ready;
	assign d_fire = d_valid && d_ready;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state_q <= hr_pkg::IDLE;
		end else begin
			case (state_q)
				hr_pkg::IDLE: begin
					if (cmd_fire)
						state_q <= hr_pkg::DATA;
				end
				hr_pkg::DATA: begin
					if (a_take && beat_last_q)
						state_q <= hr_pkg::WAIT_ACK;
				end
				hr_pkg::WAIT_ACK: begin
					if (d_fire)
						state_q <= hr_pkg::RESP;
				end
				default: begin
					if (b_take)
						state_q <= hr_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			cnt_q <= '0;
			beat_valid_q <= 1'b0;
		end else begin
			if (cmd_fire)
				cnt_q <= '0;
			else if (w_fire)
				cnt_q <= cnt_q + 1'b1;
			if (w_fire)
				beat_valid_q <= 1'b1;
			else if (a_take)
				beat_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			addr_q <= cmd.addr;
			len_q <= cmd.len;
		end
		if (w_fire) begin
			beat_data_q <= w.data;
			beat_strb_q <= w.strb;
			beat_last_q <= (cnt_q == len_q);
		end
		if (d_fire) begin
			if (d.denied)
				resp_q <= hr_pkg::SLVERR;
			else
				resp_q <= hr_pkg::OKAY;
		end
	end

	always_comb begin
		a_beat.source = source;
		a_beat.address = addr_q;
		a_beat.mask = beat_strb_q;
		a_beat.data = beat_data_q;
		a_beat.last = beat_last_q;
		// log2 of total burst bytes
		case (len_q)
			2'd0: a_beat.size = `HR_SIZE_W'(2);
			2'd1: a_beat.size = `HR_SIZE_W'(3);
			default: a_beat.size = `HR_SIZE_W'(4);
		endcase
		if (&beat_strb_q)
			a_beat.opcode = hr_pkg::PUT_FULL;
		else
			a_beat.opcode = hr_pkg::PUT_PARTIAL;
	end

endmodule

//--- design/hr_pkg.sv
`include "hr_params.svh"

package hr_pkg;

	typedef enum logic [1:0] {
		IDLE,
		DATA,
		WAIT_ACK,
		RESP
	} hr_state_e;

	typedef enum logic [2:0] {
		PUT_FULL = 3'd0,
		PUT_PARTIAL = 3'd1
	} tl_a_op_e;

	typedef enum logic [2:0] {
		ACCESS_ACK = 3'd0
	} tl_d_op_e;

	typedef enum logic [1:0] {
		OKAY = 2'd0,
		SLVERR = 2'd2
	} axi_resp_e;

	typedef struct packed {
		logic [`HR_ID_W-1:0] id;
		logic [`HR_ADDR_W-1:0] addr;
		logic [`HR_LEN_W-1:0] len;
	} ax_cmd_t;

	typedef struct packed {
		logic [`HR_ID_W-1:0] id;
		logic [`HR_DATA_W-1:0] data;
		logic [`HR_STRB_W-1:0] strb;
		logic last;
	} w_beat_t;

	// One A beat; last marks the final beat of a Put burst
	typedef struct packed {
		tl_a_op_e opcode;
		logic [`HR_SIZE_W-1:0] size;
		logic [`HR_ID_W-1:0] source;
		logic [`HR_ADDR_W-1:0] address;
		logic [`HR_STRB_W-1:0] mask;
		logic [`HR_DATA_W-1:0] data;
		logic last;
	} tl_a_t;

	typedef struct packed {
		tl_d_op_e opcode;
		logic [`HR_ID_W-1:0] source;
		logic denied;
	} tl_d_t;

	typedef struct packed {
		logic [`HR_ID_W-1:0] id;
		axi_resp_e resp;
	} b_resp_t;

endpackage

//--- design/hr_params.svh
`ifndef HR_PARAMS_SVH
`define HR_PARAMS_SVH

// Bus widths
`define HR_ADDR_W 32
`define HR_DATA_W 32
`define HR_STRB_W 4

// Handler array, one entry per AXI ID
`define HR_ENTRIES 4
`define HR_ID_W 2

`define HR_LEN_W 2
`define HR_SIZE_W 3

`define HR_RESP_DEPTH 2

`endif
